// File: soc_bus.f
source/soc_bus_pkg.sv
source/wb_if.sv
source/wb_pri_arbiter.sv
source/bus_decoder.sv
source/info_regs.sv
source/wb_ram.sv
source/soc_bus.sv
verification/soc_bus_properties.sv
verification/soc_bus_tb.sv

// File: verification/soc_bus_tb.sv
module soc_bus_tb;

    localparam int N_RAM     = 16;
    localparam int N_SCRATCH = 8;
    localparam int N_BAD     = 4;
    // every transfer in the sequence below, counted per section
    localparam int N_OPS     = 3 * N_RAM + 2 * N_SCRATCH + 2 * N_BAD + 13;

    logic i_clk;
    logic i_rst_n;
    logic df_cyc, df_stb, df_we, if_cyc, if_stb, if_we;
    soc_bus_pkg::wb_addr_t df_addr, if_addr;
    soc_bus_pkg::wb_data_t df_wdata, if_wdata;
    soc_bus_pkg::wb_sel_t  df_sel, if_sel;
    logic df_ack, df_err, df_stall, if_ack, if_err, if_stall, irq;
    soc_bus_pkg::wb_data_t df_rdata, if_rdata;

    int mismatches = 0;
    int failures = 0;
    int done_order[$];

    // reference model state
    soc_bus_pkg::wb_data_t ram_model [1024];
    soc_bus_pkg::wb_data_t scratch_model = '0;
    soc_bus_pkg::wb_addr_t err_model = '0;

    soc_bus UUT (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_df_cyc(df_cyc), .i_df_stb(df_stb), .i_df_we(df_we), .i_df_addr(df_addr),
        .i_df_wdata(df_wdata), .i_df_sel(df_sel), .o_df_ack(df_ack), .o_df_err(df_err),
        .o_df_stall(df_stall), .o_df_rdata(df_rdata),
        .i_if_cyc(if_cyc), .i_if_stb(if_stb), .i_if_we(if_we), .i_if_addr(if_addr),
        .i_if_wdata(if_wdata), .i_if_sel(if_sel), .o_if_ack(if_ack), .o_if_err(if_err),
        .o_if_stall(if_stall), .o_if_rdata(if_rdata), .o_irq(irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic drive(input int m, input logic c, input logic s);
        if (m == 0) begin
            df_cyc = c;
            df_stb = s;
        end else begin
            if_cyc = c;
            if_stb = s;
        end
    endtask

    // one request on master m (0 data, 1 instruction), called between edges
    task automatic xfer(input int m, input logic we, input soc_bus_pkg::wb_addr_t a,
                        input soc_bus_pkg::wb_data_t d, input soc_bus_pkg::wb_sel_t s,
                        output soc_bus_pkg::wb_data_t rd, output logic got_err,
                        output int waits);
        int lat;
        logic resp;
        @(negedge i_clk);
        if (m == 0) begin
            {df_we, df_addr, df_wdata, df_sel} = {we, a, d, s};
        end else begin
            {if_we, if_addr, if_wdata, if_sel} = {we, a, d, s};
        end
        drive(m, 1'b1, 1'b1);
        waits = 0;
        #2;
        while ((m == 0) ? df_stall : if_stall) begin
            waits++;
            @(negedge i_clk);
            #2;
        end
        @(posedge i_clk);
        @(negedge i_clk);
        drive(m, 1'b1, 1'b0);
        lat = 1;
        resp = (m == 0) ? (df_ack || df_err) : (if_ack || if_err);
        while (!resp && lat < 10) begin
            @(negedge i_clk);
            lat++;
            resp = (m == 0) ? (df_ack || df_err) : (if_ack || if_err);
        end
        if (!resp) begin
            failures++;
            $display("no response from the bus for address %h", a);
        end
        check("latency", 2, lat);
        rd = (m == 0) ? df_rdata : if_rdata;
        got_err = (m == 0) ? df_err : if_err;
        if (got_err && ((m == 0) ? df_ack : if_ack)) begin
            failures++;
            $display("ack and err returned together for address %h", a);
        end
        drive(m, 1'b0, 1'b0);
        done_order.push_back(m);
    endtask

    function automatic soc_bus_pkg::wb_addr_t info_addr(input logic [3:0] ofs);
        return {soc_bus_pkg::INFO_BLOCK, 17'd0, ofs};
    endfunction

    initial begin
        repeat (N_OPS * 8 + 100) @(posedge i_clk);
        $display("timeout: the run did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

    initial begin
        soc_bus_pkg::wb_addr_t addrs [N_RAM];
        soc_bus_pkg::wb_addr_t bad;
        soc_bus_pkg::wb_data_t d;
        soc_bus_pkg::wb_data_t rd;
        soc_bus_pkg::wb_data_t first;
        soc_bus_pkg::wb_sel_t s;
        logic e;
        int w;
        int w2;
        void'($urandom(11));
        i_rst_n = 1'b0;
        {df_cyc, df_stb, df_we, df_addr, df_wdata, df_sel} = '0;
        {if_cyc, if_stb, if_we, if_addr, if_wdata, if_sel} = '0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        check("reset outputs", 5'b0, {df_ack, df_err, if_ack, if_err, irq});
        xfer(0, 0, info_addr(soc_bus_pkg::INFO_OFS_SCRATCH), 0, 4'hf, rd, e, w);
        check("reset scratch", 0, rd);
        xfer(0, 0, info_addr(soc_bus_pkg::INFO_OFS_ERRADDR), 0, 4'hf, rd, e, w);
        check("reset erraddr", 0, rd);

        // RAM: full write, random byte-select write, read back
        for (int i = 0; i < N_RAM; i++) begin
            addrs[i] = $urandom % 1024;
            d = $urandom;
            xfer(0, 1, addrs[i], d, 4'hf, rd, e, w);
            ram_model[addrs[i]] = d;
        end
        for (int i = 0; i < N_RAM; i++) begin
            d = $urandom;
            s = $urandom;
            xfer(i % 2, 1, addrs[i], d, s, rd, e, w);
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    ram_model[addrs[i]][8*b +: 8] = d[8*b +: 8];
                end
            end
        end
        for (int i = 0; i < N_RAM; i++) begin
            xfer(i % 2, 0, addrs[i], 0, 4'hf, rd, e, w);
            check("ram read", ram_model[addrs[i]], rd);
        end

        // register block
        xfer(1, 0, info_addr(soc_bus_pkg::INFO_OFS_ID), 0, 4'hf, rd, e, w);
        check("id read", soc_bus_pkg::SOC_ID, rd);
        for (int i = 0; i < N_SCRATCH; i++) begin
            scratch_model = $urandom;
            xfer(0, 1, info_addr(soc_bus_pkg::INFO_OFS_SCRATCH), scratch_model,
                 $urandom, rd, e, w);
            xfer(0, 0, info_addr(soc_bus_pkg::INFO_OFS_SCRATCH), 0, 4'hf, rd, e, w);
            check("scratch read", scratch_model, rd);
        end

        // unmapped addresses
        for (int i = 0; i < N_BAD; i++) begin
            bad = {9'(2 + $urandom % 510), 21'($urandom)};
            err_model = bad;
            xfer(i % 2, i[0], bad, $urandom, 4'hf, rd, e, w);
            check("unmapped err", 1, e);
            xfer(0, 0, info_addr(soc_bus_pkg::INFO_OFS_ERRADDR), 0, 4'hf, rd, e, w);
            check("erraddr read", {2'b00, err_model} * 32'd4, rd);
        end

        // interrupt flag set then cleared
        for (int v = 1; v >= 0; v--) begin
            xfer(0, 1, info_addr(soc_bus_pkg::INFO_OFS_IRQ), v, 4'hf, rd, e, w);
            check("irq output", v, irq);
            xfer(0, 0, info_addr(soc_bus_pkg::INFO_OFS_IRQ), 0, 4'hf, rd, e, w);
            check("irq read", v, rd);
        end

        // simultaneous request on an idle bus last owned by the data master
        done_order.delete();
        fork
            xfer(0, 0, addrs[0], 0, 4'hf, rd, e, w);
            xfer(1, 0, addrs[1], 0, 4'hf, d, e, w2);
        join
        check("tie winner", 0, done_order[0]);
        check("tie data waits", 0, w);
        if (w2 == 0) begin
            failures++;
            $display("instruction master was not stalled during a data transfer");
        end
        check("tie inst data", ram_model[addrs[1]], d);

        // instruction master already holds the bus
        done_order.delete();
        fork
            xfer(1, 0, addrs[2], 0, 4'hf, d, e, w2);
            begin
                @(negedge i_clk);
                xfer(0, 0, addrs[3], 0, 4'hf, rd, e, w);
            end
        join
        check("held owner", 1, done_order[0]);
        if (w == 0) begin
            failures++;
            $display("data master was not stalled while the instruction master held the bus");
        end
        check("held data read", ram_model[addrs[3]], rd);

        // power counter
        xfer(0, 0, info_addr(soc_bus_pkg::INFO_OFS_POWER), 0, 4'hf, first, e, w);
        xfer(1, 0, info_addr(soc_bus_pkg::INFO_OFS_POWER), 0, 4'hf, rd, e, w);
        if (rd <= first) begin
            failures++;
            $display("power counter did not increase: %h then %h", first, rd);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verification/soc_bus_properties.sv
module soc_bus_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_stb,
    input logic i_stall,
    input logic i_ack,
    input logic i_err
);

    logic accept;

    assign accept = i_stb && !i_stall;

    // one response kind per cycle
    ack_err_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_ack && i_err))
        else $error("ack and err high in the same cycle");

    // fixed two cycle response latency
    response_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        accept |-> ##2 (i_ack || i_err))
        else $error("accepted request got no response two cycles later");

    // no response without a matching request
    no_stray_response: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ack || i_err) |-> $past(accept, 2))
        else $error("response without a request two cycles earlier");

    // decoder never holds off the master
    no_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n) !i_stall)
        else $error("decoder raised stall");

endmodule

bind bus_decoder soc_bus_properties u_props (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_stb   (mbus.stb),
    .i_stall (mbus.stall),
    .i_ack   (mbus.ack),
    .i_err   (mbus.err)
);

// File: source/soc_bus.sv
module soc_bus #(
    parameter int RAM_AW = 10
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // data master
    input  logic                  i_df_cyc,
    input  logic                  i_df_stb,
    input  logic                  i_df_we,
    input  soc_bus_pkg::wb_addr_t i_df_addr,
    input  soc_bus_pkg::wb_data_t i_df_wdata,
    input  soc_bus_pkg::wb_sel_t  i_df_sel,
    output logic                  o_df_ack,
    output logic                  o_df_err,
    output logic                  o_df_stall,
    output soc_bus_pkg::wb_data_t o_df_rdata,

    // instruction master
    input  logic                  i_if_cyc,
    input  logic                  i_if_stb,
    input  logic                  i_if_we,
    input  soc_bus_pkg::wb_addr_t i_if_addr,
    input  soc_bus_pkg::wb_data_t i_if_wdata,
    input  soc_bus_pkg::wb_sel_t  i_if_sel,
    output logic                  o_if_ack,
    output logic                  o_if_err,
    output logic                  o_if_stall,
    output soc_bus_pkg::wb_data_t o_if_rdata,

    output logic                  o_irq
);

    wb_if mbus ();
    wb_if ram_bus ();
    wb_if info_bus ();

    // bus error report toward the register block
    logic                  err_strobe;
    soc_bus_pkg::wb_addr_t err_addr;

    // data fetch wins ties over instruction fetch
    wb_pri_arbiter u_arbiter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_df_cyc   (i_df_cyc),
        .i_df_stb   (i_df_stb),
        .i_df_we    (i_df_we),
        .i_df_addr  (i_df_addr),
        .i_df_wdata (i_df_wdata),
        .i_df_sel   (i_df_sel),
        .o_df_ack   (o_df_ack),
        .o_df_err   (o_df_err),
        .o_df_stall (o_df_stall),
        .o_df_rdata (o_df_rdata),
        .i_if_cyc   (i_if_cyc),
        .i_if_stb   (i_if_stb),
        .i_if_we    (i_if_we),
        .i_if_addr  (i_if_addr),
        .i_if_wdata (i_if_wdata),
        .i_if_sel   (i_if_sel),
        .o_if_ack   (o_if_ack),
        .o_if_err   (o_if_err),
        .o_if_stall (o_if_stall),
        .o_if_rdata (o_if_rdata),
        .mbus       (mbus.master)
    );

    bus_decoder #(.RAM_AW(RAM_AW)) u_decoder (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .mbus         (mbus.slave),
        .ram_bus      (ram_bus.master),
        .info_bus     (info_bus.master),
        .o_err_strobe (err_strobe),
        .o_err_addr   (err_addr)
    );

    wb_ram #(.RAM_AW(RAM_AW)) u_ram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (ram_bus.slave)
    );

    info_regs u_info (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .bus          (info_bus.slave),
        .i_err_strobe (err_strobe),
        .i_err_addr   (err_addr),
        .o_irq        (o_irq)
    );

endmodule

// File: source/wb_ram.sv
module wb_ram #(
    parameter int RAM_AW = 10
) (
    input  logic i_clk,
    input  logic i_rst_n,
    wb_if.slave  bus
);

    localparam int DEPTH = 1 << RAM_AW;

    soc_bus_pkg::wb_data_t mem [DEPTH];
    logic [RAM_AW-1:0]     widx;
    logic                  req;

    assign req  = bus.cyc && bus.stb;
    assign widx = bus.addr[RAM_AW-1:0];

    // single-cycle memory, no back-pressure and no faults
    assign bus.stall = 1'b0;
    assign bus.err   = 1'b0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
        end
    end

    // byte lanes written only where sel is set
    always_ff @(posedge i_clk) begin
        if (req && bus.we) begin
            for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
                if (bus.sel[b]) begin
                    mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req && !bus.we) begin
            bus.rdata <= mem[widx];
        end
    end

endmodule

// File: source/info_regs.sv
module info_regs (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    wb_if.slave                   bus,
    input  logic                  i_err_strobe,
    input  soc_bus_pkg::wb_addr_t i_err_addr,
    output logic                  o_irq
);

    logic                  req;
    logic [3:0]            ofs;
    soc_bus_pkg::wb_data_t scratch_q;
    soc_bus_pkg::wb_addr_t err_addr_q;
    soc_bus_pkg::wb_data_t power_q;
    logic                  irq_q;

    assign req = bus.cyc && bus.stb;
    assign ofs = bus.addr[3:0];

    // never waits, never faults
    assign bus.stall = 1'b0;
    assign bus.err   = 1'b0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bus.ack    <= 1'b0;
            scratch_q  <= '0;
            irq_q      <= 1'b0;
            err_addr_q <= '0;
            power_q    <= '0;
        end else begin
            bus.ack <= req;
            if (req && bus.we) begin
                case (ofs)
                    soc_bus_pkg::INFO_OFS_SCRATCH: scratch_q <= bus.wdata;
                    soc_bus_pkg::INFO_OFS_IRQ:     irq_q     <= bus.wdata[0];
                    default: ;
                endcase
            end
            if (i_err_strobe) begin
                err_addr_q <= i_err_addr;
            end
            // top bit latches on the first wrap of the low 31 bits
            power_q <= {power_q[31] | (&power_q[30:0]), power_q[30:0] + 31'd1};
        end
    end

    always_ff @(posedge i_clk) begin
        if (req) begin
            case (ofs)
                soc_bus_pkg::INFO_OFS_ID:      bus.rdata <= soc_bus_pkg::SOC_ID;
                soc_bus_pkg::INFO_OFS_SCRATCH: bus.rdata <= scratch_q;
                soc_bus_pkg::INFO_OFS_ERRADDR: bus.rdata <= {err_addr_q, 2'b00};
                soc_bus_pkg::INFO_OFS_POWER:   bus.rdata <= power_q;
                soc_bus_pkg::INFO_OFS_IRQ:     bus.rdata <= {31'd0, irq_q};
                default:                       bus.rdata <= '0;
            endcase
        end
    end

    assign o_irq = irq_q;

endmodule

// File: source/bus_decoder.sv
module bus_decoder #(
    parameter int RAM_AW = 10
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    wb_if.slave                   mbus,
    wb_if.master                  ram_bus,
    wb_if.master                  info_bus,
    output logic                  o_err_strobe,
    output soc_bus_pkg::wb_addr_t o_err_addr
);

    logic ram_sel;
    logic info_sel;
    logic none_sel;
    logic accept;
    logic err_dly_q;

    // block 0 low words hold the RAM, everything above its size is a hole
    assign ram_sel  = (mbus.addr[soc_bus_pkg::ADDR_W-1:RAM_AW] == '0);
    assign info_sel = (mbus.addr[soc_bus_pkg::BLOCK_MSB:soc_bus_pkg::BLOCK_LSB]
                       == soc_bus_pkg::INFO_BLOCK);
    assign none_sel = !ram_sel && !info_sel;

    // only the addressed slave may hold the master off
    assign mbus.stall = (ram_sel && ram_bus.stall) || (info_sel && info_bus.stall);
    assign accept     = mbus.stb && !mbus.stall;

    // RAM port
    assign ram_bus.cyc   = mbus.cyc;
    assign ram_bus.stb   = mbus.stb && ram_sel;
    assign ram_bus.we    = mbus.we;
    assign ram_bus.addr  = mbus.addr;
    assign ram_bus.wdata = mbus.wdata;
    assign ram_bus.sel   = mbus.sel;

    // register block port
    assign info_bus.cyc   = mbus.cyc;
    assign info_bus.stb   = mbus.stb && info_sel;
    assign info_bus.we    = mbus.we;
    assign info_bus.addr  = mbus.addr;
    assign info_bus.wdata = mbus.wdata;
    assign info_bus.sel   = mbus.sel;

    // error capture sees the failed address on the accepting edge
    assign o_err_strobe = accept && none_sel;
    assign o_err_addr   = mbus.addr;

    // unmapped error waits one stage so it lines up with slave acks
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_dly_q <= 1'b0;
        end else begin
            err_dly_q <= o_err_strobe;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mbus.ack <= 1'b0;
            mbus.err <= 1'b0;
        end else begin
            mbus.ack <= ram_bus.ack || info_bus.ack;
            mbus.err <= err_dly_q || ram_bus.err || info_bus.err;
        end
    end

    // return data from whichever slave answered
    always_ff @(posedge i_clk) begin
        if (ram_bus.ack) begin
            mbus.rdata <= ram_bus.rdata;
        end else if (info_bus.ack) begin
            mbus.rdata <= info_bus.rdata;
        end
    end

endmodule

// File: source/wb_pri_arbiter.sv
module wb_pri_arbiter (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // data master
    input  logic                  i_df_cyc,
    input  logic                  i_df_stb,
    input  logic                  i_df_we,
    input  soc_bus_pkg::wb_addr_t i_df_addr,
    input  soc_bus_pkg::wb_data_t i_df_wdata,
    input  soc_bus_pkg::wb_sel_t  i_df_sel,
    output logic                  o_df_ack,
    output logic                  o_df_err,
    output logic                  o_df_stall,
    output soc_bus_pkg::wb_data_t o_df_rdata,

    // instruction master
    input  logic                  i_if_cyc,
    input  logic                  i_if_stb,
    input  logic                  i_if_we,
    input  soc_bus_pkg::wb_addr_t i_if_addr,
    input  soc_bus_pkg::wb_data_t i_if_wdata,
    input  soc_bus_pkg::wb_sel_t  i_if_sel,
    output logic                  o_if_ack,
    output logic                  o_if_err,
    output logic                  o_if_stall,
    output soc_bus_pkg::wb_data_t o_if_rdata,

    // merged bus toward the decoder
    wb_if.master                  mbus
);

    soc_bus_pkg::owner_e owner_q;
    soc_bus_pkg::owner_e grant;
    logic                owner_cyc;
    logic                df_owns;

    assign owner_cyc = (owner_q == soc_bus_pkg::OWN_DATA) ? i_df_cyc : i_if_cyc;

    // ownership only moves once the current owner has let go of cyc
    always_comb begin
        grant = owner_q;
        if (!owner_cyc) begin
            if (i_df_cyc) begin
                grant = soc_bus_pkg::OWN_DATA;
            end else if (i_if_cyc) begin
                grant = soc_bus_pkg::OWN_INST;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            owner_q <= soc_bus_pkg::OWN_DATA;
        end else begin
            owner_q <= grant;
        end
    end

    assign df_owns = (grant == soc_bus_pkg::OWN_DATA);

    // request mux, the loser's strobe never reaches the bus
    assign mbus.cyc   = df_owns ? i_df_cyc   : i_if_cyc;
    assign mbus.stb   = df_owns ? i_df_stb   : i_if_stb;
    assign mbus.we    = df_owns ? i_df_we    : i_if_we;
    assign mbus.addr  = df_owns ? i_df_addr  : i_if_addr;
    assign mbus.wdata = df_owns ? i_df_wdata : i_if_wdata;
    assign mbus.sel   = df_owns ? i_df_sel   : i_if_sel;

    // responses back to whoever owns the bus
    assign o_df_ack   = df_owns && mbus.ack;
    assign o_df_err   = df_owns && mbus.err;
    assign o_if_ack   = !df_owns && mbus.ack;
    assign o_if_err   = !df_owns && mbus.err;

    // the waiting master is held off
    assign o_df_stall = !df_owns || mbus.stall;
    assign o_if_stall = df_owns || mbus.stall;

    assign o_df_rdata = mbus.rdata;
    assign o_if_rdata = mbus.rdata;

endmodule

// File: source/wb_if.sv
interface wb_if;

    // request side
    logic                  cyc;
    logic                  stb;
    logic                  we;
    soc_bus_pkg::wb_addr_t addr;
    soc_bus_pkg::wb_data_t wdata;
    soc_bus_pkg::wb_sel_t  sel;

    // response side
    logic                  ack;
    logic                  err;
    logic                  stall;
    soc_bus_pkg::wb_data_t rdata;

    modport master (
        output cyc,
        output stb,
        output we,
        output addr,
        output wdata,
        output sel,
        input  ack,
        input  err,
        input  stall,
        input  rdata
    );

    // err and stall are tied low by plain memory slaves
    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  addr,
        input  wdata,
        input  sel,
        output ack,
        output err,
        output stall,
        output rdata
    );

endinterface

// File: source/soc_bus_pkg.sv
package soc_bus_pkg;

    // bus geometry
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // word address, data word and byte lanes
    typedef logic [ADDR_W-1:0] wb_addr_t;
    typedef logic [DATA_W-1:0] wb_data_t;
    typedef logic [SEL_W-1:0]  wb_sel_t;

    // memory map, split into 8 MB blocks by the top word-address bits
    localparam int BLOCK_MSB = 29;
    localparam int BLOCK_LSB = 21;

    // block 0 holds the RAM, block 1 the register block
    localparam logic [BLOCK_MSB-BLOCK_LSB:0] INFO_BLOCK = 9'd1;

    // register block offsets, word address bits 3..0
    localparam logic [3:0] INFO_OFS_ID      = 4'h0;
    localparam logic [3:0] INFO_OFS_SCRATCH = 4'h1;
    localparam logic [3:0] INFO_OFS_ERRADDR = 4'h2;
    localparam logic [3:0] INFO_OFS_POWER   = 4'h3;
    localparam logic [3:0] INFO_OFS_IRQ     = 4'h4;

    // read-only identification word
    localparam wb_data_t SOC_ID = 32'h20191028;

    // who holds the shared bus
    typedef enum logic {
        OWN_DATA,
        OWN_INST
    } owner_e;

endpackage
